// ==== dma_rd_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_arbiter
  import dma_rd_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [`DMA_RD_CHANNELS-1:0] req_i,
  input  wire dma_rd_chan_req_t            chan_i [`DMA_RD_CHANNELS],
  input  wire logic                        done_i,
  output logic [`DMA_RD_CHANNELS-1:0]      ack_o,
  output logic                             cmd_valid_o,
  output dma_rd_cmd_t                      cmd_o
);

  localparam int N  = `DMA_RD_CHANNELS;
  localparam int HW = $clog2(`DMA_RD_HOLDOFF + 1);

  logic [N-1:0]   req_q;
  logic [N-1:0]   holding;
  logic [HW-1:0]  hold_cnt [N];
  logic [N-1:0]   base;
  logic           busy;
  logic [2*N-1:0] req_dbl;
  logic [2*N-1:0] pick_dbl;
  logic [N-1:0]   gnt;
  dma_rd_chan_req_t win_req;

  // channel is masked for a few cycles after its grant
  always_comb
  begin
    for (int k = 0; k < N; k++)
      holding[k] = (hold_cnt[k] != '0);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      req_q <= '0;
    else
      req_q <= req_i & ~holding;
  end

  // first requester at or after base, wrapping around
  assign req_dbl  = {req_q, req_q};
  assign pick_dbl = req_dbl & ~(req_dbl - {{N{1'b0}}, base});
  assign gnt      = busy ? '0 : (pick_dbl[N-1:0] | pick_dbl[2*N-1:N]);

  always_comb
  begin
    win_req = '0;
    for (int k = 0; k < N; k++)
      if (gnt[k])
        win_req = chan_i[k];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ack_o       <= '0;
      cmd_valid_o <= 1'b0;
      busy        <= 1'b0;
      base        <= N'(1);
      for (int k = 0; k < N; k++)
        hold_cnt[k] <= '0;
    end
    else
    begin
      ack_o       <= gnt;
      cmd_valid_o <= |gnt;
      if (|gnt)
      begin
        busy <= 1'b1;
        base <= {gnt[N-2:0], gnt[N-1]};
      end
      else if (done_i)
        busy <= 1'b0;
      for (int k = 0; k < N; k++)
      begin
        if (gnt[k])
          hold_cnt[k] <= HW'(`DMA_RD_HOLDOFF);
        else if (holding[k])
          hold_cnt[k] <= hold_cnt[k] - 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (|gnt)
      cmd_o <= '{addr: win_req.addr, len: win_req.len, chan: gnt};
  end

  a_ack_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ack_o));

endmodule

`default_nettype wire

// ==== dma_rd_cfg.svh ====
`ifndef DMA_RD_CFG_SVH
`define DMA_RD_CFG_SVH

// number of requesting channels
`define DMA_RD_CHANNELS 8

// word address and length width, in 8-byte words
`define DMA_RD_WADDR_W 27

// read data width
`define DMA_RD_DATA_W 64

// byte address bits below one word
`define DMA_RD_BYTE_SHIFT 3

// depth of data and tag buffers, also the read credit limit
`define DMA_RD_FIFO_DEPTH 16

// cycles a channel stays masked after its ack
`define DMA_RD_HOLDOFF 4

`endif

// ==== dma_rd_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_engine
  import dma_rd_pkg::*;
(
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic [`DMA_RD_CHANNELS-1:0] req_i,
  input  wire dma_rd_chan_req_t            chan_i [`DMA_RD_CHANNELS],
  output logic [`DMA_RD_CHANNELS-1:0]      ack_o,
  output logic                             arvalid_o,
  input  wire logic                        arready_i,
  output logic [`DMA_RD_WADDR_W+`DMA_RD_BYTE_SHIFT-1:0] araddr_o,
  input  wire logic                        rvalid_i,
  input  wire dma_rd_data_t                rdata_i,
  output logic                             rready_o,
  input  wire logic                        dout_rdy_i,
  output dma_rd_data_t                     dout_o,
  output logic [`DMA_RD_CHANNELS-1:0]      dout_en_o,
  output logic                             dout_eop_o
);

  dma_rd_cmd_t  cmd;
  logic         cmd_valid;
  logic         done;
  logic         tag_push;
  dma_rd_tag_t  tag_in;
  dma_rd_tag_t  tag_head;
  dma_rd_data_t data_head;
  logic         data_empty;
  logic         data_full;
  logic         pop;

  dma_rd_arbiter i_dma_rd_arbiter (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .chan_i      (chan_i),
    .done_i      (done),
    .ack_o       (ack_o),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd)
  );

  dma_rd_issue i_dma_rd_issue (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .arready_i    (arready_i),
    .credit_ret_i (pop),
    .arvalid_o    (arvalid_o),
    .araddr_o     (araddr_o),
    .tag_push_o   (tag_push),
    .tag_o        (tag_in),
    .done_o       (done)
  );

  dma_rd_fifo #(.T(dma_rd_data_t), .DEPTH(`DMA_RD_FIFO_DEPTH)) i_data_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (rvalid_i & rready_o),
    .din_i   (rdata_i),
    .pop_i   (pop),
    .dout_o  (data_head),
    .empty_o (data_empty),
    .full_o  (data_full)
  );

  // tags run ahead of data, never behind
  dma_rd_fifo #(.T(dma_rd_tag_t), .DEPTH(`DMA_RD_FIFO_DEPTH)) i_tag_fifo (
    .clk     (clk),
    .rst     (rst),
    .push_i  (tag_push),
    .din_i   (tag_in),
    .pop_i   (pop),
    .dout_o  (tag_head),
    .empty_o (),
    .full_o  ()
  );

  assign rready_o = ~data_full;
  assign pop      = ~data_empty & dout_rdy_i;

  always_ff @(posedge clk)
  begin
    dout_o <= data_head;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      dout_en_o  <= '0;
      dout_eop_o <= 1'b0;
    end
    else
    begin
      dout_en_o  <= pop ? tag_head.chan : '0;
      dout_eop_o <= pop & tag_head.last;
    end
  end

  // credit limit keeps the data buffer from ever refusing a returned word
  a_rready_held: assert property (@(posedge clk) disable iff (rst) rvalid_i |-> rready_o);

endmodule

`default_nettype wire

// ==== dma_rd_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = `DMA_RD_FIFO_DEPTH
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic push_i,
  input  wire T     din_i,
  input  wire logic pop_i,
  output T          dout_o,
  output logic      empty_o,
  output logic      full_o
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T               mem [DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;

  always_ff @(posedge clk)
  begin
    if (push_i)
      mem[wr_ptr] <= din_i;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_i)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // head entry is visible without a pop
  assign dout_o  = mem[rd_ptr];
  assign empty_o = (count == '0);
  assign full_o  = (count == (AW+1)'(DEPTH));

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push_i && full_o));
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop_i && empty_o));

endmodule

`default_nettype wire

// ==== dma_rd_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module dma_rd_issue
  import dma_rd_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst,
  input  wire logic  cmd_valid_i,
  input  wire dma_rd_cmd_t cmd_i,
  input  wire logic  arready_i,
  input  wire logic  credit_ret_i,
  output logic       arvalid_o,
  output logic [`DMA_RD_WADDR_W+`DMA_RD_BYTE_SHIFT-1:0] araddr_o,
  output logic       tag_push_o,
  output dma_rd_tag_t tag_o,
  output logic       done_o
);

  localparam int W  = `DMA_RD_WADDR_W;
  localparam int CW = $clog2(`DMA_RD_FIFO_DEPTH + 1);

  logic [W-1:0]                  waddr;
  logic [W-1:0]                  remain;
  logic [`DMA_RD_CHANNELS-1:0]   chan;
  logic                          active;
  logic [CW-1:0]                 credit;
  logic                          hs;
  logic                          last;

  assign hs   = arvalid_o & arready_i;
  assign last = (remain == W'(1));

  // credit only drops on a handshake, so araddr stays put while valid
  assign arvalid_o = active & (credit != '0);
  assign araddr_o  = {waddr, {`DMA_RD_BYTE_SHIFT{1'b0}}};
  assign done_o    = hs & last;

  assign tag_push_o = hs;
  assign tag_o      = '{chan: chan, last: last};

  always_ff @(posedge clk)
  begin
    if (rst)
      active <= 1'b0;
    else if (cmd_valid_i)
      active <= 1'b1;
    else if (done_o)
      active <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (cmd_valid_i)
    begin
      waddr  <= cmd_i.addr;
      remain <= cmd_i.len;
      chan   <= cmd_i.chan;
    end
    else if (hs)
    begin
      waddr  <= waddr + 1'b1;
      remain <= remain - 1'b1;
    end
  end

  // one credit per free slot in the data buffer
  always_ff @(posedge clk)
  begin
    if (rst)
      credit <= CW'(`DMA_RD_FIFO_DEPTH);
    else
      case ({credit_ret_i, hs})
        2'b10:   credit <= credit + 1'b1;
        2'b01:   credit <= credit - 1'b1;
        default: credit <= credit;
      endcase
  end

  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credit <= CW'(`DMA_RD_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== dma_rd_pkg.sv ====
`default_nettype none

`include "dma_rd_cfg.svh"

package dma_rd_pkg;

  // request as presented by one channel
  typedef struct packed {
    logic [`DMA_RD_WADDR_W-1:0] addr;
    logic [`DMA_RD_WADDR_W-1:0] len;
  } dma_rd_chan_req_t;

  // transfer handed from arbiter to issue logic
  typedef struct packed {
    logic [`DMA_RD_WADDR_W-1:0]  addr;
    logic [`DMA_RD_WADDR_W-1:0]  len;
    logic [`DMA_RD_CHANNELS-1:0] chan;
  } dma_rd_cmd_t;

  // side info kept per issued read
  typedef struct packed {
    logic [`DMA_RD_CHANNELS-1:0] chan;
    logic                        last;
  } dma_rd_tag_t;

  typedef logic [`DMA_RD_DATA_W-1:0] dma_rd_data_t;

endpackage

`default_nettype wire

// ==== sources.f ====
+incdir+.
dma_rd_pkg.sv
dma_rd_fifo.sv
dma_rd_arbiter.sv
dma_rd_issue.sv
dma_rd_engine.sv
tb_dma_rd_engine.sv

// ==== tb_dma_rd_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dma_rd_cfg.svh"

module tb_dma_rd_engine
  import dma_rd_pkg::*;
();

  localparam int N = `DMA_RD_CHANNELS;
  localparam int DEPTH = `DMA_RD_FIFO_DEPTH;
  localparam logic [63:0] DATA_OFS = 64'ha5c3_0000_0000_0000;
  localparam int RDY_ON = 0;
  localparam int RDY_OFF = 1;
  localparam int RDY_RANDOM = 2;

  logic clk = 1'b0;
  logic rst;
  logic [N-1:0] req_i;
  dma_rd_chan_req_t chan_i [N];
  logic [N-1:0] ack_o;
  logic arvalid_o, arready_i, rvalid_i, rready_o;
  logic [`DMA_RD_WADDR_W+`DMA_RD_BYTE_SHIFT-1:0] araddr_o;
  dma_rd_data_t rdata_i, dout_o;
  logic dout_rdy_i, dout_eop_o;
  logic [N-1:0] dout_en_o;

  logic [63:0] pend_addr [$];
  int pend_due [$];
  logic [N-1:0] exp_en [$];
  dma_rd_data_t exp_data [$];
  logic exp_eop [$];
  int ack_log [$];
  int ack_cnt [N] = '{default: 0};
  int ar_cnt = 0, out_cnt = 0, cyc = 0;
  int rdy_mode = RDY_ON;
  logic [31:0] rng, len_rng;
  logic ar_acc = 1'b0, rd_acc = 1'b0;
  logic [N-1:0] ack_seen = '0;
  logic [63:0] ar_addr;

  dma_rd_engine i_dma_rd_engine (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else abort_run($sformatf("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp));
  endtask

  // expected words from the channel's own request
  task automatic expect_packet(input int k);
    for (int i = 0; i < chan_i[k].len; i++)
    begin
      exp_en.push_back(N'(1) << k);
      exp_data.push_back(((64'(chan_i[k].addr) + 64'(i)) << `DMA_RD_BYTE_SHIFT) + DATA_OFS);
      exp_eop.push_back(i == chan_i[k].len - 1);
    end
    ack_log.push_back(k);
    ack_cnt[k]++;
  endtask

  task automatic check_word;
    assert (exp_data.size() > 0)
    else abort_run("an output word arrived while no word was expected");
    check_value("dout_en_o", dout_en_o, exp_en.pop_front());
    check_value("dout_o", dout_o, exp_data.pop_front());
    check_value("dout_eop_o", dout_eop_o, exp_eop.pop_front());
    out_cnt++;
  endtask

  // sample everything mid-cycle away from the edge
  always @(negedge clk)
  begin
    if (!rst)
    begin
      ar_acc   = arvalid_o & arready_i;
      ar_addr  = 64'(araddr_o);
      rd_acc   = rvalid_i & rready_o;
      ack_seen = ack_o;
      if (ar_acc)
        ar_cnt++;
      if (rvalid_i)
        assert (rready_o) else abort_run("read data was refused while rvalid_i was high");
      for (int k = 0; k < N; k++)
        if (ack_o[k])
          expect_packet(k);
      if (dout_en_o != '0)
        check_word();
      assert (ar_cnt - out_cnt <= DEPTH)
      else abort_run("more reads outstanding than the data buffer can hold");
    end
  end

  // memory responder and stream receiver
  always @(posedge clk)
  begin
    #1;
    cyc++;
    for (int k = 0; k < N; k++)
      if (ack_seen[k])
        req_i[k] = 1'b0;
    if (rd_acc)
    begin
      void'(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
    if (ar_acc)
    begin
      pend_addr.push_back(ar_addr);
      pend_due.push_back(cyc + int'(rng[5:4]));
    end
    rng = xorshift(rng);
    arready_i = (rng[1:0] != 2'b00);
    rvalid_i = (pend_addr.size() > 0) && (pend_due[0] <= cyc);
    if (pend_addr.size() > 0)
      rdata_i = pend_addr[0] + DATA_OFS;
    else
      rdata_i = '0;
    dout_rdy_i = (rdy_mode == RDY_ON) || (rdy_mode == RDY_RANDOM && rng[3:2] != 2'b00);
  end

  task automatic next_drive_slot;
    @(posedge clk);
    #1;
  endtask

  task automatic post_request(input int k, input int addr, input int len);
    chan_i[k] = '{addr: addr, len: len};
    req_i[k]  = 1'b1;
  endtask

  task automatic wait_acks(input int target);
    int t;
    t = 0;
    while (ack_log.size() < target)
    begin
      @(posedge clk);
      t++;
      assert (t < 2000) else abort_run("timed out waiting for a channel ack");
    end
  endtask

  task automatic wait_drain;
    int t;
    t = 0;
    while (exp_data.size() > 0)
    begin
      @(posedge clk);
      t++;
      assert (t < 5000) else abort_run("timed out waiting for expected words");
    end
  endtask

  task automatic single_transfer;
    int first, start_out;
    first = ack_log.size();
    start_out = out_cnt;
    next_drive_slot();
    post_request(3, 'h100, 5);
    wait_acks(first + 1);
    wait_drain();
    check_value("acked channel", ack_log[first], 3);
    check_value("word count", out_cnt - start_out, 5);
  endtask

  task automatic one_word_transfer;
    int start_out;
    start_out = out_cnt;
    next_drive_slot();
    post_request(7, 'h7fff0, 1);
    wait_acks(ack_log.size() + 1);
    wait_drain();
    repeat (8) @(posedge clk);
    check_value("ack count ch7", ack_cnt[7], 1);
    check_value("word count", out_cnt - start_out, 1);
  endtask

  task automatic round_robin_order;
    int first;
    first = ack_log.size();
    next_drive_slot();
    for (int k = 0; k < N; k++)
      post_request(k, 'h1000 + k * 64, k + 2);
    wait_acks(first + N);
    wait_drain();
    for (int k = 0; k < N; k++)
      check_value("ack order", ack_log[first + k], k);
  endtask

  task automatic rotation_after_grant;
    int first;
    first = ack_log.size();
    next_drive_slot();
    post_request(2, 'h2000, 3);
    wait_acks(first + 1);
    wait_drain();
    next_drive_slot();
    post_request(1, 'h2100, 4);
    post_request(5, 'h2200, 2);
    wait_acks(first + 3);
    wait_drain();
    check_value("first after ch2", ack_log[first + 1], 5);
    check_value("second after ch2", ack_log[first + 2], 1);
  endtask

  task automatic back_pressure;
    int t;
    rdy_mode = RDY_OFF;
    next_drive_slot();
    dout_rdy_i = 1'b0;
    post_request(4, 'h3000, 40);
    wait_acks(ack_log.size() + 1);
    t = 0;
    while (!(ar_cnt - out_cnt == DEPTH && pend_addr.size() == 0))
    begin
      @(posedge clk);
      t++;
      assert (t < 2000) else abort_run("timed out waiting for the data buffer to fill");
    end
    repeat (20)
    begin
      next_drive_slot();
      check_value("arvalid_o", arvalid_o, 1'b0);
    end
    @(posedge clk);
    rdy_mode = RDY_ON;
    wait_drain();
  endtask

  task automatic random_stalls;
    int first;
    first = ack_log.size();
    rdy_mode = RDY_RANDOM;
    next_drive_slot();
    for (int k = 0; k < N; k++)
    begin
      len_rng = xorshift(len_rng);
      post_request(k, 'h4000 + k * 256, int'(len_rng % 24) + 1);
    end
    wait_acks(first + N);
    wait_drain();
    rdy_mode = RDY_ON;
  endtask

  initial
  begin
    rng = 32'hdf91_bf41;
    len_rng = 32'hdf91_bf41;
    rst = 1'b1;
    req_i = '0;
    arready_i = 1'b0;
    rvalid_i = 1'b0;
    rdata_i = '0;
    dout_rdy_i = 1'b1;
    for (int k = 0; k < N; k++)
      chan_i[k] = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    single_transfer();
    one_word_transfer();
    round_robin_order();
    rotation_after_grant();
    back_pressure();
    random_stalls();
    check_value("total words", out_cnt, ar_cnt);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
